//--- design/st_glue_consts.svh
/*
 * st glue constants
 * address map prefixes, io register windows and autovector numbers
 */
`ifndef ST_GLUE_CONSTS_SVH
`define ST_GLUE_CONSTS_SVH

// dtack timeout, counted in cpu slots
`define ST_DTACK_TIMEOUT   3'd7

// rom and cartridge windows, compared against the top address bits
`define ST_TOS256_PREFIX   6'b111000   // a23..a18, $e00000-$e3ffff
`define ST_TOS192_A_PREFIX 7'b1111110  // a23..a17, $fc0000-$fdffff
`define ST_TOS192_B_PREFIX 8'b11111110 // a23..a16, $fe0000-$feffff
`define ST_CART_PREFIX     7'b1111101  // a23..a17, $fa0000-$fbffff

// io page and interrupt acknowledge space
`define ST_IO_PREFIX       8'hff       // a23..a16
`define ST_IACK_PREFIX     20'hfffff   // a23..a4

// io register windows inside $ffxxxx, base and size in bytes
`define ST_MMU_BASE        16'h8000
`define ST_MMU_SIZE        16'd2
`define ST_VREG_BASE       16'h8200
`define ST_VREG_SIZE       16'd128
`define ST_DMA_BASE        16'h8600
`define ST_DMA_SIZE        16'd16
`define ST_PSG_BASE        16'h8800
`define ST_PSG_SIZE        16'd256
`define ST_MFP_BASE        16'hfa00
`define ST_MFP_SIZE        16'd64
`define ST_ACIA_BASE       16'hfc00
`define ST_ACIA_SIZE       16'd256

// vectors supplied for the autovector levels
`define ST_VEC_VBI         8'h1c       // level 4
`define ST_VEC_HBI         8'h1a       // level 2

`endif

//--- design/st_glue_pkg.sv
/*
 * st glue shared types
 * bus phase slots, ram size codes, interrupt levels and the cpu word address
 */
`default_nettype none

package st_glue_pkg;

	// one ram slot per clk_8, four slots per cpu bus cycle
	typedef enum logic [1:0] {
		PH_VIDEO = 2'd0, // shifter fetch
		PH_CPU   = 2'd1, // cpu owns ram and io
		PH_IO    = 2'd2,
		PH_SPARE = 2'd3
	} bus_phase_t;

	// st ram size as set by the io controller
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_t;

	// 68000 ipl levels used on the st, also a3..a1 of an iack cycle
	typedef enum logic [2:0] {
		IRQ_HBI = 3'd2,
		IRQ_VBI = 3'd4,
		IRQ_MFP = 3'd6
	} irq_level_t;

	typedef logic [23:1] word_addr_t; // a23..a1, no a0 on the 68000

endpackage

`default_nettype wire

//--- design/st_ram_arbiter.sv
/*
 * st ram arbiter
 * four-phase slot sequencer sharing one ram between shifter and cpu,
 * with the registered cpu address strobe
 */
`default_nettype none

module st_ram_arbiter (
	input  wire logic                   clk_8,
	input  wire logic                   pll_locked,
	input  wire st_glue_pkg::word_addr_t cpu_addr,
	input  wire logic                   cpu_as_n,
	input  wire logic                   cpu_uds_n,
	input  wire logic                   cpu_lds_n,
	input  wire logic                   cpu_rw,
	input  wire logic                   bus_req,
	input  wire st_glue_pkg::word_addr_t video_addr,
	input  wire logic                   video_read,
	input  wire logic                   cpu2mem,
	input  wire logic                   cpu2ram_wr,
	output st_glue_pkg::bus_phase_t     bus_phase,
	output logic                        addr_strobe,
	output st_glue_pkg::word_addr_t     ram_addr,
	output logic                        ram_oe_n,
	output logic                        ram_we_n,
	output logic                        ram_uds_n,
	output logic                        ram_lds_n
);

	// slot counter and strobe, strobe sampled in the video slot
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			bus_phase <= st_glue_pkg::PH_VIDEO;
			addr_strobe <= 1'b0;
		end else begin
			bus_phase <= st_glue_pkg::bus_phase_t'(bus_phase + 2'd1); // wraps after spare
			// bus request holds the cpu off the ram
			addr_strobe <= (bus_phase == st_glue_pkg::PH_VIDEO) && !cpu_as_n && !bus_req;
		end
	end

	// ram port mux
	always_comb begin
		ram_addr = cpu_addr;
		ram_oe_n = 1'b1;
		ram_we_n = 1'b1;
		ram_uds_n = cpu_uds_n;
		ram_lds_n = cpu_lds_n;
		case (bus_phase)
			st_glue_pkg::PH_VIDEO: begin
				ram_addr = video_addr;
				ram_oe_n = !video_read; // shifter reads whole words
				ram_uds_n = 1'b0;
				ram_lds_n = 1'b0;
			end
			st_glue_pkg::PH_CPU: begin
				ram_oe_n = !(addr_strobe && cpu_rw && cpu2mem); // ram and rom reads
				ram_we_n = !(addr_strobe && cpu2ram_wr); // size-limited writes only
			end
			default: ;
		endcase
	end

	// a cpu write always follows the video slot that sampled its strobe
	a_we_in_cpu_slot: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!ram_we_n |-> (bus_phase == st_glue_pkg::PH_CPU) &&
			($past(bus_phase) == st_glue_pkg::PH_VIDEO) && $past(!cpu_as_n));

endmodule

`default_nettype wire

//--- design/st_addr_decode.sv
/*
 * st address decoder
 * ram, rom and cartridge windows, ram size write limit,
 * io chip selects and interrupt acknowledge cycles
 */
`default_nettype none

`include "st_glue_consts.svh"

module st_addr_decode (
	input  wire st_glue_pkg::word_addr_t cpu_addr,
	input  wire logic                   cpu_rw,
	input  wire st_glue_pkg::mem_size_t  mem_cfg,
	input  wire logic                   addr_strobe,
	input  wire st_glue_pkg::bus_phase_t bus_phase,
	output logic                        cpu2mem,
	output logic                        cpu2ram_wr,
	output logic                        mmu_sel,
	output logic                        vreg_sel,
	output logic                        dma_sel,
	output logic                        psg_sel,
	output logic                        mfp_sel,
	output logic                        acia_sel,
	output logic                        io_ack,
	output logic                        iack_hit,
	output st_glue_pkg::irq_level_t     iack_level
);

	logic        ram_any;   // anywhere below $e00000
	logic        ram_wr_ok; // inside the installed ram
	logic        rom_hit;
	logic        cart_hit;
	logic        io_page;
	logic        cpu_cycle;
	logic [15:0] io_off;

	// window match inside the io page, size is a power of two
	function automatic logic io_hit(input logic [15:0] off, input logic [15:0] base,
		input logic [15:0] size);
		return (off & ~(size - 16'd1)) == base;
	endfunction

	assign ram_any = (cpu_addr[23:21] != 3'b111); // 14mb max
	assign rom_hit = (cpu_addr[23:18] == `ST_TOS256_PREFIX) ||
		(cpu_addr[23:17] == `ST_TOS192_A_PREFIX) ||
		(cpu_addr[23:16] == `ST_TOS192_B_PREFIX);
	assign cart_hit = (cpu_addr[23:17] == `ST_CART_PREFIX);

	// writes only land in ram that is really there
	always_comb begin
		case (mem_cfg)
			st_glue_pkg::MEM_14M: ram_wr_ok = ram_any;
			st_glue_pkg::MEM_8M:  ram_wr_ok = !cpu_addr[23];
			default:              ram_wr_ok = (cpu_addr[23:22] == 2'b00); // 4mb mirror
		endcase
	end

	// reads see the full 14mb, rom and cartridge are read only
	assign cpu2mem = ram_any || (cpu_rw && (rom_hit || cart_hit));
	assign cpu2ram_wr = !cpu_rw && ram_wr_ok;

	assign cpu_cycle = (bus_phase == st_glue_pkg::PH_CPU) && addr_strobe;
	assign io_page = cpu_cycle && (cpu_addr[23:16] == `ST_IO_PREFIX);
	assign io_off = {cpu_addr[15:1], 1'b0};

	assign mmu_sel  = io_page && io_hit(io_off, `ST_MMU_BASE, `ST_MMU_SIZE);
	assign vreg_sel = io_page && io_hit(io_off, `ST_VREG_BASE, `ST_VREG_SIZE);
	assign dma_sel  = io_page && io_hit(io_off, `ST_DMA_BASE, `ST_DMA_SIZE);
	assign psg_sel  = io_page && io_hit(io_off, `ST_PSG_BASE, `ST_PSG_SIZE);
	assign mfp_sel  = io_page && io_hit(io_off, `ST_MFP_BASE, `ST_MFP_SIZE);
	assign acia_sel = io_page && io_hit(io_off, `ST_ACIA_BASE, `ST_ACIA_SIZE);

	// iack cycles put the level on a3..a1
	assign iack_hit = cpu_cycle && (cpu_addr[23:4] == `ST_IACK_PREFIX);
	assign iack_level = st_glue_pkg::irq_level_t'(cpu_addr[3:1]);

	assign io_ack = mmu_sel || vreg_sel || dma_sel || psg_sel || mfp_sel || acia_sel ||
		iack_hit; // every iack answered, vector or not

	// checked as the strobe drops, on the values of the slot it covered
	a_one_select: assert property (@(negedge addr_strobe)
		$onehot0({mmu_sel, vreg_sel, dma_sel, psg_sel, mfp_sel, acia_sel}));

endmodule

`default_nettype wire

//--- design/st_bus_ctrl.sv
/*
 * st bus control
 * dtack generation, bus error after a dtack timeout,
 * cpu read data select between ram and io
 */
`default_nettype none

`include "st_glue_consts.svh"

module st_bus_ctrl (
	input  wire logic                   clk_8,
	input  wire logic                   pll_locked,
	input  wire st_glue_pkg::bus_phase_t bus_phase,
	input  wire logic                   cpu_as_n,
	input  wire logic                   cpu_clr_berr,
	input  wire logic                   bus_req,
	input  wire logic                   addr_strobe,
	input  wire logic                   cpu2mem,
	input  wire logic                   io_ack,
	input  wire logic [15:0]            io_rdata,
	input  wire logic [15:0]            ram_rdata,
	input  wire logic [7:0]             auto_vector,
	output logic                        cpu_dtack_n,
	output logic                        cpu_berr,
	output logic [15:0]                 cpu_rdata
);

	logic [2:0] dtack_timeout; // cpu slots without dtack
	logic       cpu_slot;

	assign cpu_slot = (bus_phase == st_glue_pkg::PH_CPU);

	// bus request is the only wait source so the cpu just sees no dtack
	assign cpu_dtack_n = !(((cpu2mem && addr_strobe) || io_ack) && !bus_req);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			dtack_timeout <= 3'd0;
		end else if (cpu_slot) begin
			if (dtack_timeout != `ST_DTACK_TIMEOUT) begin
				if (cpu_as_n || !cpu_dtack_n || bus_req)
					dtack_timeout <= 3'd0; // cycle ended or waiting on purpose
				else
					dtack_timeout <= dtack_timeout + 3'd1;
			end else if (cpu_clr_berr) begin
				dtack_timeout <= 3'd0; // cpu took the exception
			end
		end
	end

	assign cpu_berr = (dtack_timeout == `ST_DTACK_TIMEOUT);

	// rom reads come from the ram port too
	// autovector rides in the low byte of the io bus
	assign cpu_rdata = cpu2mem ? ram_rdata : (io_rdata | {8'h00, auto_vector});

	a_no_dtack_on_br: assert property (@(posedge clk_8) disable iff (!pll_locked)
		bus_req |-> cpu_dtack_n);

endmodule

`default_nettype wire

//--- design/st_irq_ctrl.sv
/*
 * st interrupt control
 * vbi/hbi edge latches, ipl priority encoding,
 * autovectors for levels 4 and 2, mfp acknowledge for level 6
 */
`default_nettype none

`include "st_glue_consts.svh"

module st_irq_ctrl (
	input  wire logic                   clk_8,
	input  wire logic                   pll_locked,
	input  wire logic                   vsync,
	input  wire logic                   hsync,
	input  wire logic                   mfp_irq,
	input  wire logic                   iack_hit,
	input  wire st_glue_pkg::irq_level_t iack_level,
	output logic [2:0]                  cpu_ipl_n,
	output logic                        mfp_iack,
	output logic [7:0]                  auto_vector
);

	// bit 1 vbi, bit 0 hbi
	logic [1:0] sync_1;
	logic [1:0] sync_2;
	logic [1:0] sync_d; // edge history
	logic [1:0] rise;
	logic [1:0] ack;
	logic [1:0] pend;

	assign rise = sync_2 & ~sync_d;
	assign ack[1] = iack_hit && (iack_level == st_glue_pkg::IRQ_VBI);
	assign ack[0] = iack_hit && (iack_level == st_glue_pkg::IRQ_HBI);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync_1 <= 2'b00;
			sync_2 <= 2'b00;
			sync_d <= 2'b00;
			pend <= 2'b00;
		end else begin
			sync_1 <= {vsync, hsync}; // async video timing
			sync_2 <= sync_1;
			sync_d <= sync_2;
			pend <= (pend & ~ack) | rise; // new edge wins over ack
		end
	end

	// ipl0 tied high on the st so only even levels
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			cpu_ipl_n <= 3'b111;
		end else begin
			if (mfp_irq)
				cpu_ipl_n <= ~st_glue_pkg::IRQ_MFP;
			else if (pend[1])
				cpu_ipl_n <= ~st_glue_pkg::IRQ_VBI;
			else if (pend[0])
				cpu_ipl_n <= ~st_glue_pkg::IRQ_HBI;
			else
				cpu_ipl_n <= 3'b111;
		end
	end

	// mfp places its own vector
	assign mfp_iack = iack_hit && (iack_level == st_glue_pkg::IRQ_MFP);

	always_comb begin
		auto_vector = 8'h00;
		if (ack[1])
			auto_vector = `ST_VEC_VBI;
		else if (ack[0])
			auto_vector = `ST_VEC_HBI;
	end

	a_ipl0_high: assert property (@(posedge clk_8) disable iff (!pll_locked)
		cpu_ipl_n[0]);

endmodule

`default_nettype wire

//--- design/st_glue_top.sv
/*
 * st glue top
 * bus sequencer, address decoder, interrupt and bus control
 * around the shared ram and the outside peripherals
 */
`default_nettype none

module st_glue_top (
	input  wire logic                   clk_8,
	input  wire logic                   pll_locked,
	input  wire st_glue_pkg::word_addr_t cpu_addr,
	input  wire logic                   cpu_as_n,
	input  wire logic                   cpu_uds_n,
	input  wire logic                   cpu_lds_n,
	input  wire logic                   cpu_rw,
	input  wire logic                   cpu_clr_berr,
	input  wire logic                   bus_req,
	input  wire st_glue_pkg::word_addr_t video_addr,
	input  wire logic                   video_read,
	input  wire st_glue_pkg::mem_size_t  mem_cfg,
	input  wire logic                   vsync,
	input  wire logic                   hsync,
	input  wire logic                   mfp_irq,
	input  wire logic [15:0]            io_rdata,  // ored peripheral data
	input  wire logic [15:0]            ram_rdata,
	output st_glue_pkg::bus_phase_t     bus_phase,
	output st_glue_pkg::word_addr_t     ram_addr,
	output logic                        ram_oe_n,
	output logic                        ram_we_n,
	output logic                        ram_uds_n,
	output logic                        ram_lds_n,
	output logic                        mmu_sel,
	output logic                        vreg_sel,
	output logic                        dma_sel,
	output logic                        psg_sel,
	output logic                        mfp_sel,
	output logic                        acia_sel,
	output logic                        mfp_iack,
	output logic [2:0]                  cpu_ipl_n,
	output logic                        cpu_dtack_n,
	output logic                        cpu_berr,
	output logic [15:0]                 cpu_rdata
);

	wire                     addr_strobe; // high for the cpu slot
	wire                     cpu2mem;
	wire                     cpu2ram_wr;
	wire                     io_ack;
	wire                     iack_hit;
	wire st_glue_pkg::irq_level_t iack_level;
	wire [7:0]               auto_vector;

	st_ram_arbiter st_ram_arbiter_inst (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cpu_addr    (cpu_addr),
		.cpu_as_n    (cpu_as_n),
		.cpu_uds_n   (cpu_uds_n),
		.cpu_lds_n   (cpu_lds_n),
		.cpu_rw      (cpu_rw),
		.bus_req     (bus_req),
		.video_addr  (video_addr),
		.video_read  (video_read),
		.cpu2mem     (cpu2mem),
		.cpu2ram_wr  (cpu2ram_wr),
		.bus_phase   (bus_phase),
		.addr_strobe (addr_strobe),
		.ram_addr    (ram_addr),
		.ram_oe_n    (ram_oe_n),
		.ram_we_n    (ram_we_n),
		.ram_uds_n   (ram_uds_n),
		.ram_lds_n   (ram_lds_n)
	);

	st_addr_decode st_addr_decode_inst (
		.cpu_addr    (cpu_addr),
		.cpu_rw      (cpu_rw),
		.mem_cfg     (mem_cfg),
		.addr_strobe (addr_strobe),
		.bus_phase   (bus_phase),
		.cpu2mem     (cpu2mem),
		.cpu2ram_wr  (cpu2ram_wr),
		.mmu_sel     (mmu_sel),
		.vreg_sel    (vreg_sel),
		.dma_sel     (dma_sel),
		.psg_sel     (psg_sel),
		.mfp_sel     (mfp_sel),
		.acia_sel    (acia_sel),
		.io_ack      (io_ack),
		.iack_hit    (iack_hit),
		.iack_level  (iack_level)
	);

	st_irq_ctrl st_irq_ctrl_inst (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.vsync       (vsync),
		.hsync       (hsync),
		.mfp_irq     (mfp_irq),
		.iack_hit    (iack_hit),
		.iack_level  (iack_level),
		.cpu_ipl_n   (cpu_ipl_n),
		.mfp_iack    (mfp_iack),
		.auto_vector (auto_vector)
	);

	st_bus_ctrl st_bus_ctrl_inst (
		.clk_8        (clk_8),
		.pll_locked   (pll_locked),
		.bus_phase    (bus_phase),
		.cpu_as_n     (cpu_as_n),
		.cpu_clr_berr (cpu_clr_berr),
		.bus_req      (bus_req),
		.addr_strobe  (addr_strobe),
		.cpu2mem      (cpu2mem),
		.io_ack       (io_ack),
		.io_rdata     (io_rdata),
		.ram_rdata    (ram_rdata),
		.auto_vector  (auto_vector),
		.cpu_dtack_n  (cpu_dtack_n),
		.cpu_berr     (cpu_berr),
		.cpu_rdata    (cpu_rdata)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
/*
 * testbench clock and reset
 * clk_8 with a 20 unit period, pll_locked low for the first two cycles
 */
`default_nettype none

module tb_clock_gen (
	output logic clk_8,
	output logic pll_locked
);

	initial begin
		clk_8 = 1'b0;
		forever #10 clk_8 = ~clk_8;
	end

	initial begin
		pll_locked = 1'b0; // held in reset
		repeat (2) @(posedge clk_8);
		pll_locked <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/st_glue_tb.sv
/*
 * st glue testbench
 * directed cpu bus cycles against the glue top,
 * with a stub ram and a fixed io data pattern
 */
`default_nettype none

module st_glue_tb;

	localparam logic [15:0] IO_PATTERN = 16'h5a3c; // every peripheral answers this

	logic                    clk_8;
	logic                    pll_locked;
	logic [23:1]             cpu_addr;
	logic                    cpu_as_n;
	logic                    cpu_uds_n;
	logic                    cpu_lds_n;
	logic                    cpu_rw;
	logic                    cpu_clr_berr;
	logic                    bus_req;
	logic [23:1]             video_addr;
	logic                    video_read;
	st_glue_pkg::mem_size_t  mem_cfg;
	logic                    vsync;
	logic                    hsync;
	logic                    mfp_irq;
	logic [15:0]             io_rdata;
	logic [15:0]             ram_rdata;
	st_glue_pkg::bus_phase_t bus_phase;
	logic [23:1]             ram_addr;
	logic                    ram_oe_n;
	logic                    ram_we_n;
	logic                    ram_uds_n;
	logic                    ram_lds_n;
	logic                    mmu_sel;
	logic                    vreg_sel;
	logic                    dma_sel;
	logic                    psg_sel;
	logic                    mfp_sel;
	logic                    acia_sel;
	logic                    mfp_iack;
	logic [2:0]              cpu_ipl_n;
	logic                    cpu_dtack_n;
	logic                    cpu_berr;
	logic [15:0]             cpu_rdata;

	logic [15:0] ram_model [0:255]; // 256 words mirrored over the whole map
	logic [15:0] cpu_wdata;         // cpu data bus for the stub ram
	logic [5:0]  sel_vec;           // mmu vreg dma psg mfp acia
	int          error_count = 0;
	int          check_count = 0;

	tb_clock_gen clock_gen_inst (
		.clk_8      (clk_8),
		.pll_locked (pll_locked)
	);

	st_glue_top st_glue_top_inst (
		.clk_8        (clk_8),
		.pll_locked   (pll_locked),
		.cpu_addr     (cpu_addr),
		.cpu_as_n     (cpu_as_n),
		.cpu_uds_n    (cpu_uds_n),
		.cpu_lds_n    (cpu_lds_n),
		.cpu_rw       (cpu_rw),
		.cpu_clr_berr (cpu_clr_berr),
		.bus_req      (bus_req),
		.video_addr   (video_addr),
		.video_read   (video_read),
		.mem_cfg      (mem_cfg),
		.vsync        (vsync),
		.hsync        (hsync),
		.mfp_irq      (mfp_irq),
		.io_rdata     (io_rdata),
		.ram_rdata    (ram_rdata),
		.bus_phase    (bus_phase),
		.ram_addr     (ram_addr),
		.ram_oe_n     (ram_oe_n),
		.ram_we_n     (ram_we_n),
		.ram_uds_n    (ram_uds_n),
		.ram_lds_n    (ram_lds_n),
		.mmu_sel      (mmu_sel),
		.vreg_sel     (vreg_sel),
		.dma_sel      (dma_sel),
		.psg_sel      (psg_sel),
		.mfp_sel      (mfp_sel),
		.acia_sel     (acia_sel),
		.mfp_iack     (mfp_iack),
		.cpu_ipl_n    (cpu_ipl_n),
		.cpu_dtack_n  (cpu_dtack_n),
		.cpu_berr     (cpu_berr),
		.cpu_rdata    (cpu_rdata)
	);

	// stub ram with async read and clocked write
	assign ram_rdata = ram_model[ram_addr[8:1]];
	assign sel_vec = {mmu_sel, vreg_sel, dma_sel, psg_sel, mfp_sel, acia_sel};
	assign io_rdata = (sel_vec != 6'd0) ? IO_PATTERN : 16'h0000; // ored peripheral bus

	always @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			for (int i = 0; i < 256; i++)
				ram_model[i] <= {i[7:0], i[7:0] ^ 8'ha5}; // fill from the word index
		end else if (!ram_we_n) begin
			ram_model[ram_addr[8:1]] <= cpu_wdata;
		end
	end

	task automatic compare_hex(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// one cpu bus cycle returning what the cpu saw at dtack
	task automatic bus_cycle(input logic [23:0] addr, input logic rw, input logic [15:0] wdata,
		output logic [15:0] rdata, output logic [5:0] sel_seen, output logic iack_seen,
		output logic we_seen);
		int   cycles;
		logic got_dtack;
		cycles = 0;
		got_dtack = 1'b0;
		rdata = 16'h0000;
		sel_seen = 6'd0;
		iack_seen = 1'b0;
		we_seen = 1'b0;
		@(posedge clk_8);
		cpu_addr <= addr[23:1];
		cpu_rw <= rw;
		cpu_wdata <= wdata;
		cpu_as_n <= 1'b0;
		while (!got_dtack && cycles < 40) begin
			@(negedge clk_8); // mid slot where decode has settled
			cycles++;
			if (!ram_we_n)
				we_seen = 1'b1;
			if (!cpu_dtack_n) begin
				got_dtack = 1'b1;
				rdata = cpu_rdata;
				sel_seen = sel_vec;
				iack_seen = mfp_iack;
				// cpu slot hands the cpu address and byte strobes to the ram
				compare_hex("ram_addr", 32'(ram_addr), 32'(addr[23:1]));
				compare_hex("ram_uds_n ram_lds_n", 32'({ram_uds_n, ram_lds_n}), 32'h0);
			end
		end
		check_count++;
		assert (got_dtack) else begin
			$display("no dtack for the bus cycle at address %h", addr);
			error_count++;
		end
		@(posedge clk_8);
		cpu_as_n <= 1'b1;
		cpu_rw <= 1'b1;
	endtask

	task automatic wait_ipl(input logic [2:0] exp);
		int cycles;
		cycles = 0;
		@(negedge clk_8);
		while (cpu_ipl_n !== exp && cycles < 20) begin
			@(negedge clk_8);
			cycles++;
		end
		compare_hex("cpu_ipl_n", 32'(cpu_ipl_n), 32'(exp));
	endtask

	task automatic reset_values;
		int cycles;
		cycles = 0;
		while (pll_locked !== 1'b1 && cycles < 10) begin
			@(negedge clk_8);
			cycles++;
		end
		check_count++;
		assert (pll_locked === 1'b1) else begin
			$display("pll_locked was never released");
			error_count++;
		end
		compare_hex("bus_phase", 32'(bus_phase), 32'(st_glue_pkg::PH_VIDEO));
		compare_hex("cpu_ipl_n", 32'(cpu_ipl_n), 32'h7);
		compare_hex("cpu_berr", 32'(cpu_berr), 32'h0);
		compare_hex("cpu_dtack_n", 32'(cpu_dtack_n), 32'h1);
		compare_hex("select vector", 32'(sel_vec), 32'h0);
		compare_hex("ram_oe_n", 32'(ram_oe_n), 32'h1);
		compare_hex("ram_we_n", 32'(ram_we_n), 32'h1);
	endtask

	task automatic ram_access;
		logic [23:0] addr;
		logic [15:0] data;
		logic [15:0] rdata;
		logic [15:0] rom_exp;
		logic [5:0]  sel;
		logic        iack;
		logic        we;
		addr = 24'($urandom) & 24'h3ffffe; // inside 4mb, even
		data = 16'($urandom);
		bus_cycle(addr, 1'b0, data, rdata, sel, iack, we);
		compare_hex("ram_we_n low on write", 32'(we), 32'h1);
		bus_cycle(addr, 1'b1, 16'h0000, rdata, sel, iack, we);
		compare_hex("cpu_rdata", 32'(rdata), 32'(data));
		rom_exp = ram_model[8'h00]; // $fc0000 lands on word 0 of the stub
		bus_cycle(24'hfc0000, 1'b1, 16'h0000, rdata, sel, iack, we);
		compare_hex("cpu_rdata", 32'(rdata), 32'(rom_exp));
	endtask

	task automatic ram_size_gating;
		logic [15:0] rdata;
		logic [5:0]  sel;
		logic        iack;
		logic        we;
		bus_cycle(24'h500000, 1'b0, 16'($urandom), rdata, sel, iack, we); // above 4mb
		compare_hex("ram_we_n low under 4mb", 32'(we), 32'h0);
		@(posedge clk_8);
		mem_cfg <= st_glue_pkg::MEM_8M;
		bus_cycle(24'h500000, 1'b0, 16'($urandom), rdata, sel, iack, we);
		compare_hex("ram_we_n low under 8mb", 32'(we), 32'h1);
		@(posedge clk_8);
		mem_cfg <= st_glue_pkg::MEM_4M;
	endtask

	task automatic io_decode;
		logic [23:0] io_addr [0:5];
		logic [15:0] rdata;
		logic [5:0]  sel;
		logic        iack;
		logic        we;
		io_addr = '{24'hff8000, 24'hff8240, 24'hff8604, 24'hff8800, 24'hfffa10, 24'hfffc02};
		for (int n = 0; n < 6; n++) begin
			bus_cycle(io_addr[n], 1'b1, 16'h0000, rdata, sel, iack, we);
			compare_hex("select vector", 32'(sel), 32'(6'b100000 >> n)); // mmu first
			compare_hex("cpu_rdata", 32'(rdata), 32'(IO_PATTERN));
		end
	endtask

	task automatic bus_error;
		int   cycles;
		logic dtack_seen;
		cycles = 0;
		dtack_seen = 1'b0;
		@(posedge clk_8);
		cpu_addr <= 23'h700000; // $e00000, tos rom
		cpu_rw <= 1'b0;
		cpu_as_n <= 1'b0;
		while (!cpu_berr && cycles < 64) begin
			@(negedge clk_8);
			cycles++;
			if (!cpu_dtack_n)
				dtack_seen = 1'b1;
		end
		check_count++;
		assert (cpu_berr) else begin
			$display("cpu_berr never rose for the rom write");
			error_count++;
		end
		compare_hex("cpu_dtack_n low on rom write", 32'(dtack_seen), 32'h0);
		@(posedge clk_8);
		cpu_as_n <= 1'b1;
		cpu_rw <= 1'b1;
		@(negedge clk_8);
		compare_hex("cpu_berr", 32'(cpu_berr), 32'h1); // sticky
		@(posedge clk_8);
		cpu_clr_berr <= 1'b1; // held until a cpu slot sees it
		cycles = 0;
		while (cpu_berr && cycles < 10) begin
			@(negedge clk_8);
			cycles++;
		end
		@(posedge clk_8);
		cpu_clr_berr <= 1'b0;
		compare_hex("cpu_berr", 32'(cpu_berr), 32'h0);

		// bus request holds dtack off
		cpu_addr <= 23'h000800;
		cpu_as_n <= 1'b0;
		bus_req <= 1'b1;
		dtack_seen = 1'b0;
		repeat (8) begin
			@(negedge clk_8);
			if (!cpu_dtack_n)
				dtack_seen = 1'b1;
		end
		compare_hex("cpu_dtack_n low under bus_req", 32'(dtack_seen), 32'h0);
		compare_hex("cpu_berr", 32'(cpu_berr), 32'h0);
		@(posedge clk_8);
		bus_req <= 1'b0;
		cycles = 0;
		@(negedge clk_8);
		while (cpu_dtack_n && cycles < 20) begin
			@(negedge clk_8);
			cycles++;
		end
		compare_hex("cpu_dtack_n after bus_req", 32'(cpu_dtack_n), 32'h0);
		@(posedge clk_8);
		cpu_as_n <= 1'b1;
	endtask

	task automatic irq_priority;
		@(posedge clk_8);
		hsync <= 1'b1;
		wait_ipl(3'b101); // hbi alone
		@(posedge clk_8);
		hsync <= 1'b0;
		vsync <= 1'b1;
		wait_ipl(3'b011); // vbi over hbi
		@(posedge clk_8);
		vsync <= 1'b0;
		mfp_irq <= 1'b1;
		wait_ipl(3'b001);
		@(posedge clk_8);
		mfp_irq <= 1'b0;
		wait_ipl(3'b011); // vbi still pending
	endtask

	task automatic iack_vectors;
		logic [15:0] rdata;
		logic [5:0]  sel;
		logic        iack;
		logic        we;
		bus_cycle(24'hfffff8, 1'b1, 16'h0000, rdata, sel, iack, we); // level 4
		compare_hex("cpu_rdata", 32'(rdata), 32'h1c);
		compare_hex("mfp_iack", 32'(iack), 32'h0);
		wait_ipl(3'b101); // vbi gone, hbi left
		bus_cycle(24'hfffff4, 1'b1, 16'h0000, rdata, sel, iack, we); // level 2
		compare_hex("cpu_rdata", 32'(rdata), 32'h1a);
		wait_ipl(3'b111);
		bus_cycle(24'hfffffc, 1'b1, 16'h0000, rdata, sel, iack, we); // level 6
		compare_hex("mfp_iack", 32'(iack), 32'h1);
		compare_hex("cpu_rdata", 32'(rdata), 32'h0);
	endtask

	initial begin
		void'($urandom(32'h84aece27));
		cpu_addr <= '0;
		cpu_as_n <= 1'b1;
		cpu_uds_n <= 1'b0; // word cycles only
		cpu_lds_n <= 1'b0;
		cpu_rw <= 1'b1;
		cpu_wdata <= 16'h0000;
		cpu_clr_berr <= 1'b0;
		bus_req <= 1'b0;
		video_addr <= '0;
		video_read <= 1'b0;
		mem_cfg <= st_glue_pkg::MEM_4M;
		vsync <= 1'b0;
		hsync <= 1'b0;
		mfp_irq <= 1'b0;

		reset_values();
		ram_access();
		ram_size_gating();
		io_decode();
		bus_error();
		irq_priority();
		iack_vectors();

		@(posedge clk_8);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- st_glue.f
+incdir+design
design/st_glue_pkg.sv
design/st_ram_arbiter.sv
design/st_addr_decode.sv
design/st_bus_ctrl.sv
design/st_irq_ctrl.sv
design/st_glue_top.sv
tests/tb_clock_gen.sv
tests/st_glue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the st glue testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f st_glue.f --top-module st_glue_tb \
	-Mdir "$BUILD_DIR" -o st_glue_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/st_glue_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
